// File: Makefile
# Verilator build and run for the PGCB clock-request unit

VERILATOR ?= verilator
TOP       ?= pcgu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -Wno-fatal -j 0
PASS_MSG  ?= sim passed

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the pass message shows up on a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
logic/pgcb_cfg_pkg.sv
logic/pcgu_pkg.sv
logic/pcgu_hyst_timer.sv
logic/pcgu_wake_capture.sv
logic/pcgu_clkreq_fsm.sv
logic/pcgu_top.sv
verif/pcgu_checker.sv
verif/pcgu_tb.sv

// File: logic/pcgu_clkreq_fsm.sv
// Clkack synchronizer, clock-request sequencer, registered masks, clkvld and timer opcodes
`timescale 1ns/10ps

module pcgu_clkreq_fsm #(
    parameter bit DEF_PWRON = 1'b0
) (
    input  logic                    pgcb_clk,
    input  logic                    pgcb_rst_b,
    // SoC handshake, consumer gate and PGCB status
    input  logic                    pgcb_clkack,
    input  logic                    sync_gate,
    input  logic                    pgcb_pok,
    // Status from the wake capture and timer
    input  logic                    clkreq_sustain,
    input  logic                    tmr_expired,
    // Consumer clock valid
    output logic                    sync_clkvld,
    // Controls to the wake capture
    output logic                    mask_acc_wake,
    output logic                    mask_pmc_wake,
    output logic                    clr_acc_wake,
    output logic                    clr_sustain,
    output logic                    clr_defon,
    // Timer control and present state
    output pcgu_pkg::tmr_op_t       tmr_op,
    output pcgu_pkg::clkreq_state_t state
);

    logic [pgcb_cfg_pkg::sync_stages-1:0] clkack_sync_q;
    logic                                 clkack_syn;
    logic                                 defon_vld;
    pcgu_pkg::clkreq_state_t              state_nxt;

    // Clkack is asynchronous to pgcb_clk
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b)
            clkack_sync_q <= '0;
        else
            clkack_sync_q <= {clkack_sync_q[pgcb_cfg_pkg::sync_stages-2:0], pgcb_clkack};
    end

    assign clkack_syn = clkack_sync_q[pgcb_cfg_pkg::sync_stages-1];

    // ------------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b)
            state <= pcgu_pkg::st_pmcwake;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // Grant seen and wake captured in sustain
            pcgu_pkg::st_pmcwake,
            pcgu_pkg::st_selwake: begin
                if (clkack_syn && clkreq_sustain)
                    state_nxt = pcgu_pkg::st_nosel;
            end
            pcgu_pkg::st_nosel: begin
                if (tmr_expired)
                    state_nxt = pcgu_pkg::st_ungateclk;
            end
            pcgu_pkg::st_ungateclk: begin
                if (sync_gate)
                    state_nxt = pcgu_pkg::st_gatepend;
            end
            // Gate dropped early is an abort
            pcgu_pkg::st_gatepend: begin
                if (!sync_gate)
                    state_nxt = pcgu_pkg::st_ungateclk;
                else if (tmr_expired)
                    state_nxt = pcgu_pkg::st_gateclk;
            end
            // Wake sources armed by pgcb_pok once clkack is low
            pcgu_pkg::st_gateclk: begin
                if (!clkack_syn)
                    state_nxt = pgcb_pok ? pcgu_pkg::st_selwake : pcgu_pkg::st_pmcwake;
            end
            default: state_nxt = pcgu_pkg::st_pmcwake;
        endcase
    end

    // ------------------------------------------------------------------------
    // Combinational controls
    // ------------------------------------------------------------------------
    assign clr_sustain  = (state == pcgu_pkg::st_gatepend) && (state_nxt == pcgu_pkg::st_gateclk);
    assign clr_acc_wake = (state == pcgu_pkg::st_ungateclk);
    assign clr_defon    = (state == pcgu_pkg::st_nosel) && (state_nxt == pcgu_pkg::st_ungateclk);

    // Exactly one opcode per cycle
    always_comb begin
        tmr_op = pcgu_pkg::tmr_hold;
        if (state_nxt == pcgu_pkg::st_nosel &&
            (state == pcgu_pkg::st_pmcwake || state == pcgu_pkg::st_selwake))
            tmr_op = pcgu_pkg::tmr_load_wake;
        else if (state == pcgu_pkg::st_ungateclk && state_nxt == pcgu_pkg::st_gatepend)
            tmr_op = pcgu_pkg::tmr_load_gate;
        else if (state == pcgu_pkg::st_nosel || state == pcgu_pkg::st_gatepend)
            tmr_op = pcgu_pkg::tmr_dec;
    end

    // ------------------------------------------------------------------------
    // Registered outputs
    // ------------------------------------------------------------------------

    // Default-on tracker, dropped at the first ungate
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b)
            defon_vld <= DEF_PWRON;
        else
            defon_vld <= defon_vld & ~clr_defon;
    end

    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            mask_pmc_wake <= 1'b0;
            mask_acc_wake <= 1'b1;
            sync_clkvld   <= DEF_PWRON;
        end else begin
            // PMC wake armed in both idle states, accessible wake in selwake only
            mask_pmc_wake <= (state_nxt != pcgu_pkg::st_pmcwake) &&
                             (state_nxt != pcgu_pkg::st_selwake);
            mask_acc_wake <= (state_nxt != pcgu_pkg::st_selwake);
            sync_clkvld   <= (state_nxt == pcgu_pkg::st_ungateclk) || defon_vld;
        end
    end

endmodule

// File: logic/pcgu_hyst_timer.sv
// Hysteresis down-counter with wake and gate reload, saturating decrement and expiry flag
`timescale 1ns/10ps

module pcgu_hyst_timer (
    input  logic                                 pgcb_clk,
    input  logic                                 pgcb_rst_b,
    // Control from the sequencer
    input  pcgu_pkg::tmr_op_t                    tmr_op,
    // Programmed hysteresis delays
    input  logic [pgcb_cfg_pkg::tmr_width-1:0]   t_clkwake,
    input  logic [pgcb_cfg_pkg::tmr_width-1:0]   t_clkgate,
    // Count for visa, and zero flag for the sequencer
    output logic [pgcb_cfg_pkg::tmr_width-1:0]   tmr_value,
    output logic                                 tmr_expired
);

    logic [pgcb_cfg_pkg::tmr_width-1:0] tmr_nxt;

    // Next count from the opcode
    always_comb begin
        case (tmr_op)
            pcgu_pkg::tmr_load_wake: tmr_nxt = t_clkwake;
            pcgu_pkg::tmr_load_gate: tmr_nxt = t_clkgate;
            // Stops at zero, so the count still reads zero once clkvld is up
            pcgu_pkg::tmr_dec: begin
                if (tmr_expired)
                    tmr_nxt = tmr_value;
                else
                    tmr_nxt = tmr_value - pgcb_cfg_pkg::tmr_width'(1);
            end
            default: tmr_nxt = tmr_value;
        endcase
    end

    // Counter flop
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b)
            tmr_value <= pgcb_cfg_pkg::tmr_rst_val;
        else
            tmr_value <= tmr_nxt;
    end

    // Expired once the count reaches zero
    assign tmr_expired = (tmr_value == '0);

endmodule

// File: logic/pcgu_pkg.sv
// Sequencer state enum, timer opcode enum and visa field positions for the clock-request unit
package pcgu_pkg;

    // ------------------------------------------------------------------------
    // Clock-request sequencer states
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        // Clock may be gated, only the PMC wake is armed (reset state)
        st_pmcwake   = 3'h5,
        // Clock may be gated, both wake sources armed
        st_selwake   = 3'h0,
        // Clock granted by SoC, wake hysteresis counting
        st_nosel     = 3'h1,
        // Clock valid for the consumers
        st_ungateclk = 3'h2,
        // Gate hysteresis counting, abort still possible
        st_gatepend  = 3'h3,
        // Request dropped, waiting for clkack low
        st_gateclk   = 3'h4
    } clkreq_state_t;

    // ------------------------------------------------------------------------
    // Timer control opcodes
    // ------------------------------------------------------------------------
    // One opcode per cycle keeps reload and decrement exclusive
    typedef enum logic [1:0] {
        tmr_hold      = 2'h0,
        tmr_load_wake = 2'h1,
        tmr_load_gate = 2'h2,
        tmr_dec       = 2'h3
    } tmr_op_t;

    // ------------------------------------------------------------------------
    // Visa vector layout
    // ------------------------------------------------------------------------
    // Sequencer state in bits 2:0
    localparam int visa_state_lsb   = 0;
    localparam int visa_state_width = $bits(clkreq_state_t);
    // Timer count in bits 6:3
    localparam int visa_tmr_lsb     = 3;
    // Single-bit status flags start above the timer
    localparam int visa_flag_lsb    = 7;

endpackage

// File: logic/pcgu_top.sv
// Clock-request unit top with sequencer, hysteresis timer, wake capture and visa vector
`timescale 1ns/10ps

module pcgu_top #(
    // Request and clock valid asserted out of reset when set
    parameter bit DEF_PWRON = 1'b0
) (
    input  logic                                 pgcb_clk,
    input  logic                                 pgcb_rst_b,
    // SoC clock handshake
    output logic                                 pgcb_clkreq,
    input  logic                                 pgcb_clkack,
    // Hysteresis delays
    input  logic [pgcb_cfg_pkg::tmr_width-1:0]   t_clkgate,
    input  logic [pgcb_cfg_pkg::tmr_width-1:0]   t_clkwake,
    // Consumer gate, wake and clock valid
    input  logic                                 sync_gate,
    input  logic                                 async_wake_b,
    output logic                                 sync_clkvld,
    // PGCB status and PMC wake
    input  logic                                 pgcb_pok,
    input  logic                                 async_pmc_ip_wake,
    // Debug
    output logic [pgcb_cfg_pkg::visa_width-1:0]  pcgu_visa
);

    pcgu_pkg::clkreq_state_t            state;
    pcgu_pkg::tmr_op_t                  tmr_op;
    logic [pgcb_cfg_pkg::tmr_width-1:0] tmr_value;
    logic                               tmr_expired;
    logic                               mask_acc_wake;
    logic                               mask_pmc_wake;
    logic                               clr_acc_wake;
    logic                               clr_sustain;
    logic                               clr_defon;
    logic                               clkreq_sustain;
    logic                               acc_wake_flop;
    logic                               defon_flag;

    // ------------------------------------------------------------------------
    // Sequencer, timer and wake capture
    // ------------------------------------------------------------------------
    pcgu_clkreq_fsm #(
        .DEF_PWRON (DEF_PWRON)
    ) pcgu_clkreq_fsm_inst (
        .pgcb_clk       (pgcb_clk),
        .pgcb_rst_b     (pgcb_rst_b),
        .pgcb_clkack    (pgcb_clkack),
        .sync_gate      (sync_gate),
        .pgcb_pok       (pgcb_pok),
        .clkreq_sustain (clkreq_sustain),
        .tmr_expired    (tmr_expired),
        .sync_clkvld    (sync_clkvld),
        .mask_acc_wake  (mask_acc_wake),
        .mask_pmc_wake  (mask_pmc_wake),
        .clr_acc_wake   (clr_acc_wake),
        .clr_sustain    (clr_sustain),
        .clr_defon      (clr_defon),
        .tmr_op         (tmr_op),
        .state          (state)
    );

    pcgu_hyst_timer pcgu_hyst_timer_inst (
        .pgcb_clk    (pgcb_clk),
        .pgcb_rst_b  (pgcb_rst_b),
        .tmr_op      (tmr_op),
        .t_clkwake   (t_clkwake),
        .t_clkgate   (t_clkgate),
        .tmr_value   (tmr_value),
        .tmr_expired (tmr_expired)
    );

    pcgu_wake_capture #(
        .DEF_PWRON (DEF_PWRON)
    ) pcgu_wake_capture_inst (
        .pgcb_clk          (pgcb_clk),
        .pgcb_rst_b        (pgcb_rst_b),
        .async_wake_b      (async_wake_b),
        .async_pmc_ip_wake (async_pmc_ip_wake),
        .mask_acc_wake     (mask_acc_wake),
        .mask_pmc_wake     (mask_pmc_wake),
        .clr_acc_wake      (clr_acc_wake),
        .clr_sustain       (clr_sustain),
        .clr_defon         (clr_defon),
        .pgcb_clkreq       (pgcb_clkreq),
        .clkreq_sustain    (clkreq_sustain),
        .acc_wake_flop     (acc_wake_flop),
        .defon_flag        (defon_flag)
    );

    // Visa packing, unused upper bits read zero
    always_comb begin
        pcgu_visa = '0;
        pcgu_visa[pcgu_pkg::visa_state_lsb +: pcgu_pkg::visa_state_width] = state;
        pcgu_visa[pcgu_pkg::visa_tmr_lsb +: pgcb_cfg_pkg::tmr_width]      = tmr_value;
        pcgu_visa[pcgu_pkg::visa_flag_lsb +: 6] = {defon_flag, acc_wake_flop, clkreq_sustain,
                                                   async_wake_b, sync_gate, pgcb_clkreq};
    end

endmodule

// File: logic/pcgu_wake_capture.sv
// Async wake flop, PMC wake gating, default-on flag, wake synchronizers, sustain flop and clkreq
`timescale 1ns/10ps

module pcgu_wake_capture #(
    parameter bit DEF_PWRON = 1'b0
) (
    input  logic pgcb_clk,
    input  logic pgcb_rst_b,
    // Raw wake sources
    input  logic async_wake_b,
    input  logic async_pmc_ip_wake,
    // Masks and clears from the sequencer
    input  logic mask_acc_wake,
    input  logic mask_pmc_wake,
    input  logic clr_acc_wake,
    input  logic clr_sustain,
    input  logic clr_defon,
    // Request to the SoC clock controller
    output logic pgcb_clkreq,
    output logic clkreq_sustain,
    // Debug visibility
    output logic acc_wake_flop,
    output logic defon_flag
);

    logic masked_acc_wake_b;
    logic acc_wake_assert;
    logic pmc_wake_or_defon;
    logic pmc_wake_assert;
    logic [pgcb_cfg_pkg::sync_stages-1:0] acc_sync_q;
    logic [pgcb_cfg_pkg::sync_stages-1:0] pmc_sync_q;
    logic acc_wake_sync;
    logic pmc_wake_sync;

    // ------------------------------------------------------------------------
    // Accessible wake path
    // ------------------------------------------------------------------------

    // Mask holds the set input inactive outside selwake
    assign masked_acc_wake_b = async_wake_b | mask_acc_wake;

    // Set asynchronously by the low wake, cleared synchronously once ungated
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b, negedge masked_acc_wake_b) begin
        if (!pgcb_rst_b)
            acc_wake_flop <= 1'b0;
        else if (!masked_acc_wake_b)
            acc_wake_flop <= 1'b1;
        else
            acc_wake_flop <= acc_wake_flop & ~clr_acc_wake;
    end

    // Gated off once the sustain flop owns the request
    assign acc_wake_assert = acc_wake_flop & ~mask_acc_wake;

    // ------------------------------------------------------------------------
    // PMC wake path
    // ------------------------------------------------------------------------

    // Default-on flag, only ever set when DEF_PWRON is 1
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b)
            defon_flag <= DEF_PWRON;
        else
            defon_flag <= defon_flag & ~clr_defon;
    end

    // PMC holds its wake until the domain is powered, so no capture flop
    assign pmc_wake_or_defon = async_pmc_ip_wake | defon_flag;
    assign pmc_wake_assert   = pmc_wake_or_defon & ~mask_pmc_wake;

    // ------------------------------------------------------------------------
    // Synchronizers and sustain
    // ------------------------------------------------------------------------
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b) begin
            acc_sync_q <= '0;
            pmc_sync_q <= '0;
        end else begin
            acc_sync_q <= {acc_sync_q[pgcb_cfg_pkg::sync_stages-2:0], acc_wake_assert};
            pmc_sync_q <= {pmc_sync_q[pgcb_cfg_pkg::sync_stages-2:0], pmc_wake_assert};
        end
    end

    assign acc_wake_sync = acc_sync_q[pgcb_cfg_pkg::sync_stages-1];
    assign pmc_wake_sync = pmc_sync_q[pgcb_cfg_pkg::sync_stages-1];

    // Holds the request until the sequencer leaves gatepend for gateclk
    always_ff @(posedge pgcb_clk, negedge pgcb_rst_b) begin
        if (!pgcb_rst_b)
            clkreq_sustain <= 1'b0;
        else
            clkreq_sustain <= (clkreq_sustain | acc_wake_sync | pmc_wake_sync) & ~clr_sustain;
    end

    // Rises asynchronously on either wake, falls synchronously with sustain
    assign pgcb_clkreq = acc_wake_assert | pmc_wake_assert | clkreq_sustain;

endmodule

// File: logic/pgcb_cfg_pkg.sv
// Configuration constants for timer width, synchronizer depth, timer reset value and visa width
package pgcb_cfg_pkg;

    // ------------------------------------------------------------------------
    // Hysteresis timers
    // ------------------------------------------------------------------------

    // Width of t_clkwake, t_clkgate and the down-counter
    localparam int tmr_width = 4;

    // All ones, so the counter never reads as expired out of reset
    localparam logic [tmr_width-1:0] tmr_rst_val = '1;

    // ------------------------------------------------------------------------
    // Clock domain crossing and debug
    // ------------------------------------------------------------------------

    // Flop count of each synchronizer (clkack and both wakes)
    localparam int sync_stages = 2;

    // Width of the visa debug vector
    localparam int visa_width = 16;

endpackage

// File: verif/pcgu_checker.sv
// Concurrent assertions on the clkreq, clkack and clkvld ports, and the bind into the top level
`timescale 1ns/10ps

module pcgu_checker (
    input logic pgcb_clk,
    input logic pgcb_rst_b,
    input logic pgcb_clkreq,
    input logic pgcb_clkack,
    input logic sync_clkvld
);

    // Running count of assertion failures
    int fail_cnt = 0;

    // Consumers only see a valid clock while it is requested
    clkvld_needs_clkreq: assert property (
        @(posedge pgcb_clk) disable iff (!pgcb_rst_b) sync_clkvld |-> pgcb_clkreq
    ) else begin
        $error("sync_clkvld is high while pgcb_clkreq is low");
        fail_cnt++;
    end

    // Request must be driven at all times out of reset
    clkreq_known: assert property (
        @(posedge pgcb_clk) disable iff (!pgcb_rst_b) !$isunknown(pgcb_clkreq)
    ) else begin
        $error("pgcb_clkreq is unknown");
        fail_cnt++;
    end

    // Clock only becomes valid once the SoC has granted it
    clkvld_rise_needs_clkack: assert property (
        @(posedge pgcb_clk) disable iff (!pgcb_rst_b) $rose(sync_clkvld) |-> pgcb_clkack
    ) else begin
        $error("sync_clkvld rose while pgcb_clkack was low");
        fail_cnt++;
    end

endmodule

bind pcgu_top pcgu_checker pcgu_checker_inst (
    .pgcb_clk    (pgcb_clk),
    .pgcb_rst_b  (pgcb_rst_b),
    .pgcb_clkreq (pgcb_clkreq),
    .pgcb_clkack (pgcb_clkack),
    .sync_clkvld (sync_clkvld)
);

// File: verif/pcgu_tb.sv
// Testbench with clock, reset, SoC clkack model, LFSR, reference function, directed and random tests
`timescale 1ns/10ps

module pcgu_tb;

    localparam int sel_clkreq = 0;
    localparam int sel_clkvld = 1;
    localparam int sel_clkack = 2;
    localparam int sel_idle   = 3;
    localparam int ref_wake_lat   = 0;
    localparam int ref_gate_lat   = 1;
    localparam int ref_idle_state = 2;

    logic                                pgcb_clk;
    logic                                pgcb_rst_b;
    logic                                pgcb_clkreq;
    logic                                pgcb_clkack;
    logic [pgcb_cfg_pkg::tmr_width-1:0]  t_clkgate;
    logic [pgcb_cfg_pkg::tmr_width-1:0]  t_clkwake;
    logic                                sync_gate;
    logic                                async_wake_b;
    logic                                sync_clkvld;
    logic                                pgcb_pok;
    logic                                async_pmc_ip_wake;
    logic [pgcb_cfg_pkg::visa_width-1:0] pcgu_visa;
    logic [15:0]                         lfsr;
    int                                  err_cnt;
    int                                  timeout_cnt;

    pcgu_top #(
        .DEF_PWRON (1'b0)
    ) pcgu_top_inst (
        .pgcb_clk          (pgcb_clk),
        .pgcb_rst_b        (pgcb_rst_b),
        .pgcb_clkreq       (pgcb_clkreq),
        .pgcb_clkack       (pgcb_clkack),
        .t_clkgate         (t_clkgate),
        .t_clkwake         (t_clkwake),
        .sync_gate         (sync_gate),
        .async_wake_b      (async_wake_b),
        .sync_clkvld       (sync_clkvld),
        .pgcb_pok          (pgcb_pok),
        .async_pmc_ip_wake (async_pmc_ip_wake),
        .pcgu_visa         (pcgu_visa)
    );

    initial begin
        pgcb_clk = 1'b0;
        forever #50 pgcb_clk = ~pgcb_clk;
    end

    // ------------------------------------------------------------------------
    // Random source and reference
    // ------------------------------------------------------------------------

    // Galois LFSR stepped once per output bit
    function automatic bit lfsr_next_bit();
        bit out_bit;
        out_bit = lfsr[0];
        lfsr = lfsr >> 1;
        if (out_bit)
            lfsr = lfsr ^ 16'hB400;
        return out_bit;
    endfunction

    function automatic int rand_bits(input int n);
        int val;
        int i;
        val = 0;
        for (i = 0; i < n; i++)
            val = (val << 1) | int'(lfsr_next_bit());
        return val;
    endfunction

    // Expected latency in cycles or expected idle state after a gate
    function automatic int ref_expect(input int kind, input int wake_dly, input int gate_dly,
                                      input bit pok);
        case (kind)
            ref_wake_lat: return wake_dly + pgcb_cfg_pkg::sync_stages + 2;
            ref_gate_lat: return gate_dly + 2;
            default:      return pok ? int'(pcgu_pkg::st_selwake) : int'(pcgu_pkg::st_pmcwake);
        endcase
    endfunction

    // SoC clock controller model that moves clkack to clkreq after 1 to 4 cycles
    initial begin : soc_clkack_model
        logic target;
        int   delay;
        forever begin
            @(negedge pgcb_clk);
            #1;
            if (pgcb_rst_b && pgcb_clkreq !== pgcb_clkack) begin
                target = pgcb_clkreq;
                delay = 1 + rand_bits(2);
                repeat (delay) @(negedge pgcb_clk);
                pgcb_clkack = target;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Sampling, waiting and checking
    // ------------------------------------------------------------------------

    // Just past the falling edge where every output has settled
    task automatic sample_point();
        @(negedge pgcb_clk);
        #1;
    endtask

    function automatic int visa_state();
        return int'(pcgu_visa[pcgu_pkg::visa_state_lsb +: pcgu_pkg::visa_state_width]);
    endfunction

    function automatic bit sig_value(input int sel);
        case (sel)
            sel_clkreq: return pgcb_clkreq;
            sel_clkvld: return sync_clkvld;
            sel_clkack: return pgcb_clkack;
            default:    return visa_state() == int'(pcgu_pkg::st_selwake) ||
                               visa_state() == int'(pcgu_pkg::st_pmcwake);
        endcase
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic finish_run();
        $display("Run complete: %0d errors, %0d timeouts, %0d assertion failures",
                 err_cnt, timeout_cnt, pcgu_top_inst.pcgu_checker_inst.fail_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && pcgu_top_inst.pcgu_checker_inst.fail_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    // Counts sample points until the signal reaches the level
    task automatic wait_for(input string what, input int sel, input bit val, input int limit,
                            output int cycles);
        cycles = 0;
        while (sig_value(sel) !== val && cycles < limit) begin
            sample_point();
            cycles++;
        end
        if (sig_value(sel) !== val) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            timeout_cnt++;
            finish_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------------

    // Wake through SoC grant to clkvld and release of the wake source
    task automatic wake_cycle(input string name, input bit use_pmc);
        int cycles;
        @(negedge pgcb_clk);
        if (use_pmc)
            async_pmc_ip_wake = 1'b1;
        else
            async_wake_b = 1'b0;
        #1;
        check({name, " clkreq rise"}, 1, int'(pgcb_clkreq));
        wait_for({name, " clkack high"}, sel_clkack, 1'b1, 8, cycles);
        wait_for({name, " clkvld high"}, sel_clkvld, 1'b1, 40, cycles);
        check({name, " clkvld latency"},
              ref_expect(ref_wake_lat, int'(t_clkwake), int'(t_clkgate), pgcb_pok), cycles);
        check({name, " visa timer"}, 0,
              int'(pcgu_visa[pcgu_pkg::visa_tmr_lsb +: pgcb_cfg_pkg::tmr_width]));
        @(negedge pgcb_clk);
        async_pmc_ip_wake = 1'b0;
        async_wake_b = 1'b1;
        repeat (3) sample_point();
        check({name, " clkvld held"}, 1, int'(sync_clkvld));
        check({name, " clkreq held"}, 1, int'(pgcb_clkreq));
        // Sustain flag sits three above clkreq in the visa flags
        check({name, " visa sustain"}, 1, int'(pcgu_visa[pcgu_pkg::visa_flag_lsb + 3]));
    endtask

    // Held gate through to clkreq low and the idle state
    task automatic gate_cycle(input string name, input bit pok);
        int cycles;
        @(negedge pgcb_clk);
        pgcb_pok = pok;
        sync_gate = 1'b1;
        sample_point();
        check({name, " clkvld off"}, 0, int'(sync_clkvld));
        wait_for({name, " clkreq low"}, sel_clkreq, 1'b0, 40, cycles);
        check({name, " clkreq drop latency"},
              ref_expect(ref_gate_lat, int'(t_clkwake), int'(t_clkgate), pok), cycles + 1);
        @(negedge pgcb_clk);
        sync_gate = 1'b0;
        wait_for({name, " idle state"}, sel_idle, 1'b1, 40, cycles);
        check({name, " idle state"}, ref_expect(ref_idle_state, 0, 0, pok), visa_state());
    endtask

    // Two-cycle gate pulse that ends before the gate timer runs out
    task automatic gate_abort(input string name);
        int cycles;
        @(negedge pgcb_clk);
        sync_gate = 1'b1;
        sample_point();
        check({name, " clkvld off"}, 0, int'(sync_clkvld));
        @(negedge pgcb_clk);
        sync_gate = 1'b0;
        #1;
        check({name, " clkreq kept"}, 1, int'(pgcb_clkreq));
        wait_for({name, " clkvld back"}, sel_clkvld, 1'b1, 4, cycles);
        check({name, " clkvld return"}, 1, cycles);
        check({name, " clkreq after abort"}, 1, int'(pgcb_clkreq));
    endtask

    initial begin : stimulus
        int i;
        lfsr = 16'd12;
        err_cnt = 0;
        timeout_cnt = 0;
        pgcb_rst_b = 1'b0;
        pgcb_clkack = 1'b0;
        sync_gate = 1'b0;
        async_wake_b = 1'b1;
        pgcb_pok = 1'b1;
        async_pmc_ip_wake = 1'b0;
        t_clkwake = 4'd3;
        t_clkgate = 4'd5;
        repeat (16) @(negedge pgcb_clk);
        pgcb_rst_b = 1'b1;
        sample_point();

        // Reset values
        check("reset clkreq", 0, int'(pgcb_clkreq));
        check("reset clkvld", 0, int'(sync_clkvld));
        check("reset state", int'(pcgu_pkg::st_pmcwake), visa_state());
        check("reset visa timer", (1 << pgcb_cfg_pkg::tmr_width) - 1,
              int'(pcgu_visa[pcgu_pkg::visa_tmr_lsb +: pgcb_cfg_pkg::tmr_width]));
        // Only the idle-high async_wake_b is set among the six flags
        check("reset visa flags", int'(6'b000100),
              int'(pcgu_visa[pcgu_pkg::visa_flag_lsb +: 6]));

        wake_cycle("pmc wake", 1'b1);
        @(negedge pgcb_clk);
        t_clkgate = 4'd6;
        gate_abort("gate abort");
        @(negedge pgcb_clk);
        t_clkgate = 4'd5;
        gate_cycle("gate with pok", 1'b1);

        // Accessible wake armed only in selwake
        wake_cycle("accessible wake", 1'b0);
        gate_cycle("gate without pok", 1'b0);
        @(negedge pgcb_clk);
        async_wake_b = 1'b0;
        repeat (8) begin
            sample_point();
            check("masked accessible wake", 0, int'(pgcb_clkreq));
        end
        @(negedge pgcb_clk);
        async_wake_b = 1'b1;
        wake_cycle("pmc wake after masked wake", 1'b1);
        gate_cycle("gate after pmc wake", 1'b1);

        // Random hysteresis delays
        for (i = 0; i < 6; i++) begin
            @(negedge pgcb_clk);
            t_clkwake = 4'(rand_bits(4));
            t_clkgate = 4'(rand_bits(4));
            wake_cycle("random wake", 1'b1);
            gate_cycle("random gate", 1'b1);
        end

        finish_run();
    end

endmodule
